// ==== Bender.yml ====
package:
  name: cic_interp

sources:
  - hdl/cic_pkg.sv
  - hdl/cic_apb_regs.sv
  - hdl/cic_strobe_gen.sv
  - hdl/cic_comb_chain.sv
  - hdl/cic_integrator_chain.sv
  - hdl/cic_int_shifter.sv
  - hdl/cic_interp.sv
  - target: test
    files:
      - verif/cic_interp_tb.sv

// ==== hdl/cic_apb_regs.sv ====
/*
 * APB slave with the enable and rate registers of the interpolator.
 * Zero wait states; unmapped addresses answer with pslverr.
 */
`timescale 1ns/1ps
`default_nettype none

module cic_apb_regs
	import cic_pkg::*;
(
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [apb_data_w-1:0] pwdata,
	output logic [apb_data_w-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  enable,
	output rate_t                 rate
);

	cic_reg_e reg_addr;
	logic     access;
	logic     addr_hit;
	logic     wr_en;
	rate_t    rate_wdata;

	// The address bus maps straight onto the register enum
	assign reg_addr = cic_reg_e'(paddr);

	// Access phase of a transfer, the only cycle that has an effect
	assign access = psel && penable;

	assign addr_hit = (reg_addr == reg_ctrl) || (reg_addr == reg_rate);

	// Writes to unmapped addresses are dropped here
	assign wr_en = access && pwrite && addr_hit;

	// Never any wait states
	assign pready = 1'b1;

	// Error is flagged only during the access phase
	assign pslverr = access && !addr_hit;

	// Keep the rate inside the range the shifter table was built for
	always_comb begin
		if (pwdata[7:0] < rate_min) begin
			rate_wdata = rate_min;
		end else if (pwdata[7:0] > rate_max) begin
			rate_wdata = rate_max;
		end else begin
			rate_wdata = pwdata[7:0];
		end
	end

	// Register updates land on the edge that closes the access phase
	always_ff @(posedge clock) begin
		if (rst) begin
			enable <= 1'b0;
			rate   <= rate_min;
		end else if (wr_en) begin
			case (reg_addr)
				reg_ctrl: enable <= pwdata[0];
				reg_rate: rate   <= rate_wdata;
				default: ;
			endcase
		end
	end

	// Read mux, valid as soon as the address is on the bus
	// Unused upper bits read as zero
	always_comb begin
		prdata = '0;
		case (reg_addr)
			reg_ctrl: prdata[0]   = enable;
			reg_rate: prdata[7:0] = rate;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/cic_comb_chain.sv ====
/*
 * Four comb stages running at the input sample rate.
 * Captures sample_in on strobe_in; the result is registered one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module cic_comb_chain
	import cic_pkg::*;
#(
	parameter int bw = sample_w
) (
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    enable,
	input  logic                    strobe_in,
	input  logic [bw-1:0]           sample_in,
	output logic [bw+cic_order-1:0] comb_out
);

	// Each comb can grow the value by one bit
	localparam int cw = bw + cic_order;

	// stage_val[0] is the extended sample, stage_val[k+1] the output of comb k
	logic [cw-1:0] stage_val [0:cic_order];

	// Previous input of every comb, i.e. its single delay element
	logic [cw-1:0] delay_q [0:cic_order-1];

	// Differencing is combinational across all stages
	// Only the delays and the output are registers
	always_comb begin
		stage_val[0] = {{cic_order{sample_in[bw-1]}}, sample_in};
		for (int k = 0; k < cic_order; k++) begin
			stage_val[k+1] = stage_val[k] - delay_q[k];
		end
	end

	// State advances once per input sample
	always_ff @(posedge clock) begin
		if (rst || !enable) begin
			for (int k = 0; k < cic_order; k++) begin
				delay_q[k] <= '0;
			end
			comb_out <= '0;
		end else if (strobe_in) begin
			for (int k = 0; k < cic_order; k++) begin
				delay_q[k] <= stage_val[k];
			end
			comb_out <= stage_val[cic_order];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cic_int_shifter.sv ====
/*
 * Removes the rate-cubed gain of the interpolator by picking a bw-bit
 * window out of the wide integrator result. Purely combinational.
 */
`timescale 1ns/1ps
`default_nettype none

module cic_int_shifter
	import cic_pkg::*;
#(
	parameter int bw         = sample_w,
	parameter int maxbitgain = max_bit_gain
) (
	input  rate_t                    rate,
	input  logic [bw+maxbitgain-1:0] signal_in,
	output logic [bw-1:0]            signal_out
);

	// Actual rate, one more than the stored field
	logic [7:0] actual_rate;

	// Lowest bit of the output window
	logic [4:0] shift;

	// Field is clamped to 127 upstream, so this cannot overflow
	assign actual_rate = rate + 8'd1;

	assign shift = bit_gain(actual_rate);

	// Dropping the low bits of a two's complement value rounds toward
	// minus infinity
	// The table tops out at maxbitgain, so the window stays in range
	always_comb begin
		signal_out = signal_in[shift +: bw];
	end

endmodule

`default_nettype wire

// ==== hdl/cic_integrator_chain.sv ====
/*
 * Zero-stuffing and four integrators at the output rate.
 * Modular wrap in the accumulators is harmless since the final result fits.
 */
`timescale 1ns/1ps
`default_nettype none

module cic_integrator_chain
	import cic_pkg::*;
#(
	parameter int bw         = sample_w,
	parameter int maxbitgain = max_bit_gain
) (
	input  logic                     clock,
	input  logic                     rst,
	input  logic                     enable,
	input  logic                     strobe_in,
	input  logic                     strobe_out,
	input  logic [bw+cic_order-1:0]  comb_out,
	output logic [bw+maxbitgain-1:0] integ_out,
	output logic                     out_valid
);

	localparam int cw = bw + cic_order;
	localparam int iw = bw + maxbitgain;

	// Marks the cycle in which a fresh comb result is available
	logic stuff_q;

	// Comb result for one cycle per input sample, zero in between
	logic [iw-1:0] stuffed;

	// One accumulator per integrator stage
	logic [iw-1:0] acc_q [0:cic_order-1];

	// Bit k goes high once the first sample has passed stage k
	logic [cic_order-1:0] fill_q;

	// Comb output registers one cycle after strobe_in
	always_ff @(posedge clock) begin
		if (rst || !enable) begin
			stuff_q <= 1'b0;
		end else begin
			stuff_q <= strobe_in;
		end
	end

	assign stuffed = stuff_q ? {{(iw - cw){comb_out[cw-1]}}, comb_out} : '0;

	// Every stage is a single register, so the chain has four cycles of latency
	always_ff @(posedge clock) begin
		if (rst || !enable) begin
			for (int k = 0; k < cic_order; k++) begin
				acc_q[k] <= '0;
			end
			fill_q <= '0;
		end else if (strobe_out) begin
			acc_q[0] <= acc_q[0] + stuffed;
			for (int k = 1; k < cic_order; k++) begin
				acc_q[k] <= acc_q[k] + acc_q[k-1];
			end
			fill_q <= {fill_q[cic_order-2:0], fill_q[0] | stuff_q};
		end
	end

	// Output is forced quiet as soon as enable drops
	assign integ_out = strobe_out ? acc_q[cic_order-1] : '0;
	assign out_valid = strobe_out && fill_q[cic_order-1];

endmodule

`default_nettype wire

// ==== hdl/cic_interp.sv ====
/*
 * Top level of the order-4 CIC interpolator with its APB control block.
 * Samples are requested with sample_req and leave at the clock rate.
 */
`timescale 1ns/1ps
`default_nettype none

module cic_interp
	import cic_pkg::*;
#(
	parameter int bw         = sample_w,
	parameter int maxbitgain = max_bit_gain
) (
	input  logic                  pclk,
	input  logic                  rst,
	// APB slave
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [apb_data_w-1:0] pwdata,
	output logic [apb_data_w-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,
	// Low-rate sample input, presented in the cycle of sample_req
	input  logic [bw-1:0]         sample_in,
	output logic                  sample_req,
	// Full-rate sample output
	output logic [bw-1:0]         sample_out,
	output logic                  out_valid
);

	logic                     enable;
	rate_t                    rate;
	logic                     strobe_in;
	logic                     strobe_out;
	logic [bw+cic_order-1:0]  comb_out;
	logic [bw+maxbitgain-1:0] integ_out;

	cic_apb_regs u_regs (
		.clock   (pclk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.enable  (enable),
		.rate    (rate)
	);

	cic_strobe_gen u_strobe (
		.clock      (pclk),
		.rst        (rst),
		.enable     (enable),
		.rate       (rate),
		.strobe_in  (strobe_in),
		.strobe_out (strobe_out)
	);

	// The source is asked for a sample exactly when the combs take one
	assign sample_req = strobe_in;

	cic_comb_chain #(.bw(bw)) u_comb (
		.clock     (pclk),
		.rst       (rst),
		.enable    (enable),
		.strobe_in (strobe_in),
		.sample_in (sample_in),
		.comb_out  (comb_out)
	);

	cic_integrator_chain #(.bw(bw), .maxbitgain(maxbitgain)) u_integ (
		.clock      (pclk),
		.rst        (rst),
		.enable     (enable),
		.strobe_in  (strobe_in),
		.strobe_out (strobe_out),
		.comb_out   (comb_out),
		.integ_out  (integ_out),
		.out_valid  (out_valid)
	);

	cic_int_shifter #(.bw(bw), .maxbitgain(maxbitgain)) u_shift (
		.rate       (rate),
		.signal_in  (integ_out),
		.signal_out (sample_out)
	);

endmodule

`default_nettype wire

// ==== hdl/cic_pkg.sv ====
/*
 * Shared widths, register map and gain table for the CIC interpolator.
 * Imported by the RTL modules and the testbench.
 */
`default_nettype none

package cic_pkg;

	// Number of comb and integrator stages
	// The gain table below only holds for this order
	localparam int cic_order = 4;

	// Gain growth in bits at the largest rate of 128
	localparam int max_bit_gain = 21;

	// Default sample width at the top level
	localparam int sample_w = 16;

	// APB address and data widths
	localparam int apb_addr_w = 4;
	localparam int apb_data_w = 32;

	// Rate field, which stores the actual rate minus one
	typedef logic [7:0] rate_t;

	// Legal rate field range, which covers actual rates 4 to 128
	localparam rate_t rate_min = 8'd3;
	localparam rate_t rate_max = 8'd127;

	// Register byte addresses on the APB side
	typedef enum logic [3:0] {
		reg_ctrl = 4'h0,
		reg_rate = 4'h4
	} cic_reg_e;

	// Smallest shift that removes a gain of rate cubed without overflow,
	// i.e. the ceiling of log2 of rate cubed
	// Takes the actual rate, not the stored field
	function automatic logic [4:0] bit_gain(input logic [7:0] actual_rate);
		logic [4:0] shift;
		case (actual_rate) inside
			// Exact powers of two first, then the nearest safe shift
			[8'd0:8'd4]:    shift = 5'd6;
			8'd5:           shift = 5'd7;
			8'd6:           shift = 5'd8;
			[8'd7:8'd8]:    shift = 5'd9;
			[8'd9:8'd10]:   shift = 5'd10;
			[8'd11:8'd12]:  shift = 5'd11;
			[8'd13:8'd16]:  shift = 5'd12;
			[8'd17:8'd20]:  shift = 5'd13;
			[8'd21:8'd25]:  shift = 5'd14;
			[8'd26:8'd32]:  shift = 5'd15;
			[8'd33:8'd40]:  shift = 5'd16;
			[8'd41:8'd50]:  shift = 5'd17;
			[8'd51:8'd64]:  shift = 5'd18;
			[8'd65:8'd80]:  shift = 5'd19;
			[8'd81:8'd101]: shift = 5'd20;
			default:        shift = 5'd21;
		endcase
		return shift;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/cic_strobe_gen.sv ====
/*
 * Pacing for the interpolator: one input strobe every rate+1 cycles
 * and an output strobe on every enabled cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module cic_strobe_gen
	import cic_pkg::*;
(
	input  logic  clock,
	input  logic  rst,
	input  logic  enable,
	input  rate_t rate,
	output logic  strobe_in,
	output logic  strobe_out
);

	// Cycles left until the next input request
	rate_t count;

	// Counter sits at zero while disabled, so the first enabled
	// cycle already issues an input strobe
	always_ff @(posedge clock) begin
		if (rst || !enable) begin
			count <= '0;
		end else if (count == '0) begin
			// Reloading with the field gives a period of rate+1
			count <= rate;
		end else begin
			count <= count - 8'd1;
		end
	end

	// Input request when the count runs out
	assign strobe_in = enable && (count == '0);

	// Output side runs at the full clock rate
	assign strobe_out = enable;

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/cic_pkg.sv
hdl/cic_apb_regs.sv
hdl/cic_strobe_gen.sv
hdl/cic_comb_chain.sv
hdl/cic_integrator_chain.sv
hdl/cic_int_shifter.sv
hdl/cic_interp.sv
verif/cic_interp_tb.sv

// ==== verif/cic_interp_tb.sv ====
/*
 * Testbench for the CIC interpolator. Drives APB and DC samples on the
 * falling edge, and lets concurrent assertions compare the outputs with
 * values from a small reference model kept in the testbench.
 */
`timescale 1ns/1ps
`default_nettype none

module cic_interp_tb
	import cic_pkg::*;
();

	localparam int clk_period = 20;

	// Each rate test runs 12 input periods, summed over all actual rates
	localparam int test_cycles = 12 * (4 + 8 + 16 + 32 + 64 + 128 + 5 + 10 + 100 + 128);

	// Covers reset, register tests and APB overhead around every test
	localparam int margin_cycles = 2000;

	logic        pclk = 1'b0;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [15:0] sample_in;
	logic        sample_req;
	logic [15:0] sample_out;
	logic        out_valid;

	// Reference model of what the DUT should be doing
	logic        en_model;
	rate_t       rate_model;
	logic        check_out;
	logic [15:0] exp_out;
	logic [31:0] exp_rdata;
	logic        exp_err;

	// Input request tracking for the pacing check
	logic        req_seen;
	int          since_req;

	logic [15:0] amp;

	cic_interp #(.bw(16), .maxbitgain(21)) u_dut (
		.pclk       (pclk),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.sample_in  (sample_in),
		.sample_req (sample_req),
		.sample_out (sample_out),
		.out_valid  (out_valid)
	);

	always #(clk_period / 2) pclk = ~pclk;

	task automatic stop_run();
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	// DC gain of rate cubed, then the shift from the gain table with floor rounding
	function automatic logic [15:0] dc_expect(input logic [15:0] value, input int rate);
		longint prod;
		prod = longint'($signed(value)) * rate * rate * rate;
		prod = prod >>> bit_gain(rate[7:0]);
		return prod[15:0];
	endfunction

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
			input logic err);
		@(negedge pclk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		exp_err = err;
		@(negedge pclk);
		penable = 1'b1;
		@(negedge pclk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, input logic [31:0] data,
			input logic err);
		@(negedge pclk);
		psel      = 1'b1;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = addr;
		exp_rdata = data;
		exp_err   = err;
		@(negedge pclk);
		penable = 1'b1;
		@(negedge pclk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Counts input requests seen on falling edges, where sample_req is stable
	task automatic wait_requests(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			if (sample_req) begin
				seen++;
			end
			@(negedge pclk);
		end
	endtask

	// Runs one rate for 12 input periods: 6 to settle, then 6 with the output checked
	task automatic run_rate_test(input rate_t field, input logic [15:0] value,
			input logic [15:0] expect_val);
		apb_write(reg_rate, {24'd0, field}, 1'b0);
		rate_model = field;
		sample_in  = value;
		exp_out    = expect_val;
		apb_write(reg_ctrl, 32'd1, 1'b0);
		en_model = 1'b1;
		wait_requests(7);
		check_out = 1'b1;
		wait_requests(6);
		check_out = 1'b0;
		apb_write(reg_ctrl, 32'd0, 1'b0);
		en_model = 1'b0;
	endtask

	// Cycles since the last input request, read before the DUT updates
	always @(posedge pclk) begin
		if (rst || !en_model) begin
			req_seen  <= 1'b0;
			since_req <= 0;
		end else if (sample_req) begin
			req_seen  <= 1'b1;
			since_req <= 0;
		end else begin
			since_req <= since_req + 1;
		end
	end

	idle_quiet_chk: assert property (@(posedge pclk) disable iff (rst)
		!en_model |-> (!sample_req && !out_valid && sample_out == 16'h0000))
	else begin
		$display("FAIL idle outputs: sample_req=%h out_valid=%h sample_out=%h expected 0",
			$sampled(sample_req), $sampled(out_valid), $sampled(sample_out));
		stop_run();
	end

	pready_chk: assert property (@(posedge pclk) disable iff (rst) pready)
	else begin
		$display("FAIL pready: got %h expected 1", $sampled(pready));
		stop_run();
	end

	pslverr_chk: assert property (@(posedge pclk) disable iff (rst)
		(psel && penable) |-> (pslverr == exp_err))
	else begin
		$display("FAIL pslverr: got %h expected %h", $sampled(pslverr), $sampled(exp_err));
		stop_run();
	end

	prdata_chk: assert property (@(posedge pclk) disable iff (rst)
		(psel && penable && !pwrite) |-> (prdata == exp_rdata))
	else begin
		$display("FAIL prdata: got %h expected %h", $sampled(prdata), $sampled(exp_rdata));
		stop_run();
	end

	// The first enabled cycle must already ask for a sample
	first_req_chk: assert property (@(posedge pclk) disable iff (rst)
		(en_model && !req_seen) |-> sample_req)
	else begin
		$display("FAIL sample_req: got %h expected 1", $sampled(sample_req));
		stop_run();
	end

	req_period_chk: assert property (@(posedge pclk) disable iff (rst)
		(en_model && req_seen) |-> (sample_req == (since_req == int'(rate_model))))
	else begin
		$display("FAIL sample_req: got %h expected %h (rate field %h)",
			$sampled(sample_req), $sampled(since_req == int'(rate_model)),
			$sampled(rate_model));
		stop_run();
	end

	valid_chk: assert property (@(posedge pclk) disable iff (rst)
		(en_model && check_out) |-> out_valid)
	else begin
		$display("FAIL out_valid: got %h expected 1", $sampled(out_valid));
		stop_run();
	end

	value_chk: assert property (@(posedge pclk) disable iff (rst)
		(en_model && check_out && out_valid) |-> (sample_out == exp_out))
	else begin
		$display("FAIL sample_out: got %h expected %h", $sampled(sample_out), $sampled(exp_out));
		stop_run();
	end

	initial begin
		#((test_cycles + margin_cycles) * clk_period);
		$display("Timeout: the run did not finish in the expected time");
		stop_run();
	end

	initial begin
		void'($urandom(32'h746b7b48));
		rst        = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = 4'h0;
		pwdata     = 32'h0;
		sample_in  = 16'h0000;
		en_model   = 1'b0;
		rate_model = rate_min;
		check_out  = 1'b0;
		exp_out    = 16'h0000;
		exp_rdata  = 32'h0;
		exp_err    = 1'b0;
		repeat (10) @(negedge pclk);
		rst = 1'b0;

		// Reset values, then enable written and read back
		apb_read(reg_ctrl, 32'h0, 1'b0);
		apb_read(reg_rate, 32'h3, 1'b0);
		apb_write(reg_ctrl, 32'h1, 1'b0);
		en_model = 1'b1;
		apb_read(reg_ctrl, 32'h1, 1'b0);
		apb_write(reg_ctrl, 32'h0, 1'b0);
		en_model = 1'b0;
		apb_read(reg_ctrl, 32'h0, 1'b0);

		// Rate writes outside 3 to 127 are clamped
		apb_write(reg_rate, 32'd1, 1'b0);
		rate_model = 8'd3;
		apb_read(reg_rate, 32'd3, 1'b0);
		apb_write(reg_rate, 32'd200, 1'b0);
		rate_model = 8'd127;
		apb_read(reg_rate, 32'd127, 1'b0);

		// Unmapped address errors out and leaves both registers alone
		apb_write(4'h8, 32'hffff_ffff, 1'b1);
		apb_read(4'h8, 32'h0, 1'b1);
		apb_read(reg_ctrl, 32'h0, 1'b0);
		apb_read(reg_rate, 32'd127, 1'b0);

		// Power-of-two rates give back the input exactly
		for (int k = 2; k <= 7; k++) begin
			amp = 16'($urandom());
			run_rate_test(rate_t'((1 << k) - 1), amp, amp);
		end

		// Other rates keep a gain of rate cubed over the shift
		amp = 16'($urandom());
		run_rate_test(8'd4, amp, dc_expect(amp, 5));
		amp = 16'($urandom());
		run_rate_test(8'd9, amp, dc_expect(amp, 10));
		amp = 16'($urandom());
		run_rate_test(8'd99, amp, dc_expect(amp, 100));

		// Negative full scale at the largest rate
		run_rate_test(8'd127, 16'h8000, 16'h8000);

		repeat (4) @(negedge pclk);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
